/* source/tetrisPkg.sv */
package tetrisPkg;

    ////////////////////
    // playfield geometry

    localparam int boardCols = 10;
    localparam int boardRows = 20;

    localparam int spawnCol = 3;
    localparam int spawnRow = 0;

    ////////////////////
    // screen geometry

    // address = line * screenWidth + pixel
    localparam int screenWidth = 320;
    localparam int cellPixels = 15;

    localparam int boardLeft = 10;
    localparam int boardTop = 10;

    // 2 x 4 next-piece box
    localparam int previewLeft = 212;
    localparam int previewTop = 56;

    ////////////////////
    // types

    // bits 0..3 top row left to right, bits 4..7 bottom row
    typedef logic [7:0] shapeT;
    typedef logic [2:0] shapeIdxT;

    // bit 0 is column 0
    typedef logic [boardCols-1:0] boardRowT;
    // row 0 is the top row
    typedef boardRowT [boardRows-1:0] boardT;

    // signed so a candidate can sit one step past a wall
    typedef logic signed [4:0] colT;
    typedef logic [4:0] rowT;

    typedef logic [16:0] addrT;

    typedef struct packed {
        shapeT shape;
        rowT   row;
        colT   col;
    } pieceT;

    typedef enum logic {
        statePlay,
        stateOver
    } gameStateT;

    typedef enum logic [1:0] {
        moveNone,
        moveDown,
        moveLeft,
        moveRight
    } moveT;

    ////////////////////
    // shape table

    localparam int shapeCount = 7;

    // written msb first, so the bottom row is the left nibble
    localparam shapeT shapeTable [shapeCount] = '{
        8'b0000_1111,   // bar
        8'b0111_0010,   // T
        8'b0011_0011,   // square
        8'b0011_0110,   // S
        8'b0110_0011,   // Z
        8'b0001_0111,   // J
        8'b0111_0001    // L
    };

endpackage

/* source/buttonSync.sv */
`timescale 1ns/100ps

module buttonSync (
    input  logic clk,
    input  logic rst_up,
    input  logic left,
    input  logic right,
    output logic leftPulse,
    output logic rightPulse
);

    // per stage: bit 0 left, bit 1 right
    logic [3:0][1:0] history;
    logic [1:0]      pulses;

    always_ff @(posedge clk) begin
        if (rst_up) begin
            history <= '0;
        end else begin
            history <= {history[2:0], {right, left}};
        end
    end

    // rising edge seen between stage 3 and stage 2
    assign pulses = history[2] & ~history[3];

    assign leftPulse = pulses[0];
    assign rightPulse = pulses[1];

    leftSingle: assert property (@(posedge clk) disable iff (rst_up)
        leftPulse |=> !leftPulse);

    rightSingle: assert property (@(posedge clk) disable iff (rst_up)
        rightPulse |=> !rightPulse);

endmodule

/* source/gravityTimer.sv */
`timescale 1ns/100ps

module gravityTimer #(
    parameter int tickPeriod = 25_000_000
) (
    input  logic clk,
    input  logic rst_up,
    input  logic running,
    input  logic fall,
    output logic tick
);

    // room for one step past the period
    localparam int cntBits = $clog2(tickPeriod + 2);

    logic [cntBits-1:0] count;
    logic [cntBits-1:0] step;

    // holding fall doubles the rate
    assign step = count + (fall ? cntBits'(2) : cntBits'(1));

    assign tick = running && (step >= cntBits'(tickPeriod));

    always_ff @(posedge clk) begin
        if (rst_up) begin
            count <= '0;
        end else if (tick) begin
            count <= '0;
        end else if (running) begin
            count <= step;
        end
    end

    countRange: assert property (@(posedge clk) disable iff (rst_up)
        count <= cntBits'(tickPeriod));

endmodule

/* source/collisionCheck.sv */
`timescale 1ns/100ps

module collisionCheck (
    input  tetrisPkg::pieceT candidate,
    input  tetrisPkg::boardT board,
    output logic             hit
);

    always_comb begin
        int r;
        int c;
        r = 0;
        c = 0;
        hit = 1'b0;
        for (int rr = 0; rr < 2; rr++) begin
            for (int cc = 0; cc < 4; cc++) begin
                r = int'(candidate.row) + rr;
                c = $signed(candidate.col) + cc;
                if (candidate.shape[rr * 4 + cc]) begin
                    // walls and floor first
                    if (c < 0 || c >= tetrisPkg::boardCols || r >= tetrisPkg::boardRows) begin
                        hit = 1'b1;
                    end else if (board[r][c]) begin
                        hit = 1'b1;
                    end
                end
            end
        end
    end

endmodule

/* source/pieceController.sv */
`timescale 1ns/100ps

module pieceController (
    input  logic              clk,
    input  logic              rst_up,
    input  logic              isPause,
    input  logic              tick,
    input  logic              leftPulse,
    input  logic              rightPulse,
    output logic              running,
    output logic              isFinish,
    output tetrisPkg::boardT  settledBoard,
    output tetrisPkg::pieceT  piece,
    output tetrisPkg::shapeT  nextShape
);

    tetrisPkg::gameStateT state;
    tetrisPkg::shapeIdxT  nextIdx;
    tetrisPkg::moveT      move;
    tetrisPkg::pieceT     candidate;
    tetrisPkg::pieceT     spawnPiece;
    tetrisPkg::boardT     pieceCells;
    tetrisPkg::boardT     landedBoard;
    logic                 hit;
    logic                 spawnHit;

    // cells covered by a piece, clipped to the board
    function automatic tetrisPkg::boardT placeCells(tetrisPkg::pieceT p);
        tetrisPkg::boardT cells;
        int r;
        int c;
        cells = '0;
        for (int rr = 0; rr < 2; rr++) begin
            for (int cc = 0; cc < 4; cc++) begin
                r = int'(p.row) + rr;
                c = $signed(p.col) + cc;
                if (p.shape[rr * 4 + cc] && c >= 0 && c < tetrisPkg::boardCols
                        && r < tetrisPkg::boardRows) begin
                    cells[r][c] = 1'b1;
                end
            end
        end
        return cells;
    endfunction

    assign running = !isPause && (state == tetrisPkg::statePlay);
    assign isFinish = (state == tetrisPkg::stateOver);
    assign nextShape = tetrisPkg::shapeTable[nextIdx];

    ////////////////////
    // move select, tick wins over the buttons

    always_comb begin
        move = tetrisPkg::moveNone;
        if (running) begin
            if (tick) begin
                move = tetrisPkg::moveDown;
            end else if (leftPulse) begin
                move = tetrisPkg::moveLeft;
            end else if (rightPulse) begin
                move = tetrisPkg::moveRight;
            end
        end
    end

    always_comb begin
        candidate = piece;
        case (move)
            tetrisPkg::moveDown:  candidate.row = piece.row + 1'b1;
            tetrisPkg::moveLeft:  candidate.col = piece.col - 5'sd1;
            tetrisPkg::moveRight: candidate.col = piece.col + 5'sd1;
            default:              candidate = piece;
        endcase
    end

    collisionCheck check (
        .candidate (candidate),
        .board     (settledBoard),
        .hit       (hit)
    );

    ////////////////////
    // landing and spawn

    assign pieceCells = placeCells(piece);
    assign landedBoard = settledBoard | pieceCells;

    always_comb begin
        spawnPiece.shape = nextShape;
        spawnPiece.row = tetrisPkg::rowT'(tetrisPkg::spawnRow);
        spawnPiece.col = tetrisPkg::colT'(tetrisPkg::spawnCol);
    end

    assign spawnHit = |(placeCells(spawnPiece) & landedBoard);

    always_ff @(posedge clk) begin
        if (rst_up) begin
            state <= tetrisPkg::statePlay;
            settledBoard <= '0;
            piece.shape <= tetrisPkg::shapeTable[0];
            piece.row <= tetrisPkg::rowT'(tetrisPkg::spawnRow);
            piece.col <= tetrisPkg::colT'(tetrisPkg::spawnCol);
            nextIdx <= tetrisPkg::shapeIdxT'(1);
        end else if (move != tetrisPkg::moveNone) begin
            if (!hit) begin
                piece <= candidate;
            end else if (move == tetrisPkg::moveDown) begin
                settledBoard <= landedBoard;
                // overlapping spawn stays on screen
                piece <= spawnPiece;
                if (nextIdx == tetrisPkg::shapeIdxT'(tetrisPkg::shapeCount - 1)) begin
                    nextIdx <= '0;
                end else begin
                    nextIdx <= nextIdx + 1'b1;
                end
                if (spawnHit) begin
                    state <= tetrisPkg::stateOver;
                end
            end
        end
    end

    pieceClear: assert property (@(posedge clk) disable iff (rst_up)
        state == tetrisPkg::statePlay |-> ~|(pieceCells & settledBoard));

    finishSticky: assert property (@(posedge clk) disable iff (rst_up)
        isFinish |=> isFinish);

endmodule

/* source/pixelLookup.sv */
`timescale 1ns/100ps

module pixelLookup (
    input  logic             clk,
    input  logic             rst_up,
    input  tetrisPkg::addrT  addr,
    input  tetrisPkg::boardT settledBoard,
    input  tetrisPkg::pieceT piece,
    input  tetrisPkg::shapeT nextShape,
    output logic             haveCube
);

    localparam int boardRight = tetrisPkg::boardLeft
        + tetrisPkg::boardCols * tetrisPkg::cellPixels;
    localparam int boardBottom = tetrisPkg::boardTop
        + tetrisPkg::boardRows * tetrisPkg::cellPixels;
    localparam int previewRight = tetrisPkg::previewLeft + 4 * tetrisPkg::cellPixels;
    localparam int previewBottom = tetrisPkg::previewTop + 2 * tetrisPkg::cellPixels;

    logic [8:0] line;
    logic [8:0] pixel;
    logic       cube;

    assign line = 9'(addr / tetrisPkg::screenWidth);
    assign pixel = 9'(addr % tetrisPkg::screenWidth);

    always_comb begin
        int cellRow;
        int cellCol;
        int pr;
        int pc;
        cellRow = 0;
        cellCol = 0;
        pr = 0;
        pc = 0;
        cube = 1'b0;
        if (pixel >= tetrisPkg::boardLeft && pixel < boardRight
                && line >= tetrisPkg::boardTop && line < boardBottom) begin
            cellCol = (int'(pixel) - tetrisPkg::boardLeft) / tetrisPkg::cellPixels;
            cellRow = (int'(line) - tetrisPkg::boardTop) / tetrisPkg::cellPixels;
            // offset of this cell inside the piece box
            pr = cellRow - int'(piece.row);
            pc = cellCol - $signed(piece.col);
            cube = settledBoard[cellRow][cellCol];
            if (pr >= 0 && pr < 2 && pc >= 0 && pc < 4) begin
                cube = cube | piece.shape[pr * 4 + pc];
            end
        end else if (pixel >= tetrisPkg::previewLeft && pixel < previewRight
                && line >= tetrisPkg::previewTop && line < previewBottom) begin
            pc = (int'(pixel) - tetrisPkg::previewLeft) / tetrisPkg::cellPixels;
            pr = (int'(line) - tetrisPkg::previewTop) / tetrisPkg::cellPixels;
            cube = nextShape[pr * 4 + pc];
        end
    end

    always_ff @(posedge clk) begin
        if (rst_up) begin
            haveCube <= 1'b0;
        end else begin
            haveCube <= cube;
        end
    end

endmodule

/* source/tetrisTop.sv */
`timescale 1ns/100ps

module tetrisTop #(
    parameter int tickPeriod = 25_000_000
) (
    input  logic            clk,
    input  logic            rst_up,
    input  logic            left,
    input  logic            right,
    input  logic            fall,
    input  logic            isPause,
    input  tetrisPkg::addrT addr,
    output logic            isFinish,
    output logic            haveCube,
    output logic            flag
);

    logic             leftPulse;
    logic             rightPulse;
    logic             running;
    logic             tick;
    tetrisPkg::boardT settledBoard;
    tetrisPkg::pieceT piece;
    tetrisPkg::shapeT nextShape;

    // flag is high while the game runs
    assign flag = running;

    buttonSync buttons (
        .clk        (clk),
        .rst_up     (rst_up),
        .left       (left),
        .right      (right),
        .leftPulse  (leftPulse),
        .rightPulse (rightPulse)
    );

    gravityTimer #(
        .tickPeriod (tickPeriod)
    ) gravity (
        .clk     (clk),
        .rst_up  (rst_up),
        .running (running),
        .fall    (fall),
        .tick    (tick)
    );

    pieceController game (
        .clk          (clk),
        .rst_up       (rst_up),
        .isPause      (isPause),
        .tick         (tick),
        .leftPulse    (leftPulse),
        .rightPulse   (rightPulse),
        .running      (running),
        .isFinish     (isFinish),
        .settledBoard (settledBoard),
        .piece        (piece),
        .nextShape    (nextShape)
    );

    pixelLookup lookup (
        .clk          (clk),
        .rst_up       (rst_up),
        .addr         (addr),
        .settledBoard (settledBoard),
        .piece        (piece),
        .nextShape    (nextShape),
        .haveCube     (haveCube)
    );

endmodule

/* sim/tbClock.sv */
`timescale 1ns/100ps

module tbClock (
    input  logic restart,
    output logic clk,
    output logic rst_up
);

    // cycles of reset still to go, the run starts in reset
    int resetLeft = 3;

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        if (restart) begin
            resetLeft <= 3;
        end else if (resetLeft > 0) begin
            resetLeft <= resetLeft - 1;
        end
    end

    assign rst_up = (resetLeft > 0);

endmodule

/* sim/tetrisTb.sv */
`timescale 1ns/100ps

module tetrisTb;

    localparam int tickPeriod = 40;
    localparam int boardItems = tetrisPkg::boardRows * tetrisPkg::boardCols;
    localparam int scanItems = boardItems + 8;
    // cycle budgets of the five tests in run order
    localparam int budgetCycles = 300 + 1400 + 2400 + 2000 + 6000;
    localparam longint watchLimitNs = 2 * budgetCycles * 10;

    logic            clk;
    logic            rst_up;
    logic            restart;
    logic            left;
    logic            right;
    logic            fall;
    logic            isPause;
    tetrisPkg::addrT addr;
    logic            isFinish;
    logic            haveCube;
    logic            flag;

    // reference model
    tetrisPkg::boardRowT mBoard [tetrisPkg::boardRows];
    tetrisPkg::shapeT    mShape;
    int                  mRow;
    int                  mCol;
    int                  mNextIdx;
    logic                mOver;
    int                  mCount;
    int                  mTicks;
    int                  mSpawns;
    // bit k holds the button level k+1 cycles back
    logic [3:0]          histL;
    logic [3:0]          histR;
    logic                expFlag;
    logic                expFinish;

    logic [31:0] lfsr;
    int          checks;
    int          cubeErrors;
    int          flagErrors;
    int          finishErrors;
    int          otherErrors;

    tbClock clockGen (
        .restart (restart),
        .clk     (clk),
        .rst_up  (rst_up)
    );

    tetrisTop #(
        .tickPeriod (tickPeriod)
    ) uut (
        .clk      (clk),
        .rst_up   (rst_up),
        .left     (left),
        .right    (right),
        .fall     (fall),
        .isPause  (isPause),
        .addr     (addr),
        .isFinish (isFinish),
        .haveCube (haveCube),
        .flag     (flag)
    );

    ////////////////////
    // random bits and model helpers

    function automatic int randBits(int n);
        int value;
        value = 0;
        for (int i = 0; i < n; i++) begin
            value = (value << 1) | int'(lfsr[0]);
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return value;
    endfunction

    function automatic logic blocked(tetrisPkg::shapeT shape, int row, int col);
        logic found;
        int r;
        int c;
        found = 1'b0;
        for (int k = 0; k < 8; k++) begin
            r = row + k / 4;
            c = col + k % 4;
            if (shape[k] && (c < 0 || c >= tetrisPkg::boardCols || r >= tetrisPkg::boardRows)) begin
                found = 1'b1;
            end else if (shape[k] && mBoard[r][c]) begin
                found = 1'b1;
            end
        end
        return found;
    endfunction

    function automatic logic pieceAt(int r, int c);
        int dr;
        int dc;
        dr = r - mRow;
        dc = c - mCol;
        if (dr < 0 || dr > 1 || dc < 0 || dc > 3) begin
            return 1'b0;
        end
        return mShape[dr * 4 + dc];
    endfunction

    task automatic resetModel();
        for (int r = 0; r < tetrisPkg::boardRows; r++) begin
            mBoard[r] = '0;
        end
        mShape = tetrisPkg::shapeTable[0];
        mRow = tetrisPkg::spawnRow;
        mCol = tetrisPkg::spawnCol;
        mNextIdx = 1;
        mOver = 1'b0;
        mCount = 0;
        mTicks = 0;
        mSpawns = 0;
        histL = '0;
        histR = '0;
    endtask

    task automatic landPiece();
        for (int k = 0; k < 8; k++) begin
            if (mShape[k]) begin
                mBoard[mRow + k / 4][mCol + k % 4] = 1'b1;
            end
        end
        mShape = tetrisPkg::shapeTable[mNextIdx];
        mRow = tetrisPkg::spawnRow;
        mCol = tetrisPkg::spawnCol;
        mNextIdx = (mNextIdx + 1) % tetrisPkg::shapeCount;
        mSpawns++;
        if (blocked(mShape, mRow, mCol)) begin
            mOver = 1'b1;
        end
    endtask

    ////////////////////
    // stimulus

    // one clock cycle of inputs and the model step at its closing edge
    task automatic stepCycle(logic pauseIn, logic fallIn, logic leftIn, logic rightIn);
        logic runs;
        logic pulseL;
        logic pulseR;
        int   inc;
        @(posedge clk);
        isPause <= pauseIn;
        fall <= fallIn;
        left <= leftIn;
        right <= rightIn;
        runs = !pauseIn && !mOver;
        expFlag = runs;
        expFinish = mOver;
        pulseL = histL[2] & ~histL[3];
        pulseR = histR[2] & ~histR[3];
        histL = {histL[2:0], leftIn};
        histR = {histR[2:0], rightIn};
        inc = fallIn ? 2 : 1;
        if (runs && mCount + inc >= tickPeriod) begin
            mCount = 0;
            mTicks++;
            if (blocked(mShape, mRow + 1, mCol)) begin
                landPiece();
            end else begin
                mRow++;
            end
        end else if (runs) begin
            mCount += inc;
            if (pulseL && !blocked(mShape, mRow, mCol - 1)) begin
                mCol--;
            end else if (!pulseL && pulseR && !blocked(mShape, mRow, mCol + 1)) begin
                mCol++;
            end
        end
    endtask

    task automatic resetDut();
        @(posedge clk);
        restart <= 1'b1;
        isPause <= 1'b1;
        fall <= 1'b0;
        left <= 1'b0;
        right <= 1'b0;
        addr <= '0;
        @(posedge clk);
        restart <= 1'b0;
        @(negedge clk);
        while (rst_up) begin
            @(negedge clk);
        end
        resetModel();
    endtask

    task automatic pressButton(logic goLeft);
        int hold;
        int gap;
        hold = 3 + randBits(2);
        gap = 3 + randBits(2);
        repeat (hold) stepCycle(1'b0, 1'b0, goLeft, !goLeft);
        repeat (gap) stepCycle(1'b0, 1'b0, 1'b0, 1'b0);
    endtask

    // fall held until the next spawn
    task automatic dropPiece();
        int start;
        int cycles;
        start = mSpawns;
        cycles = 0;
        while (mSpawns == start && cycles < 1000) begin
            stepCycle(1'b0, 1'b1, 1'b0, 1'b0);
            cycles++;
        end
        if (mSpawns == start) begin
            otherErrors++;
            $display("piece did not land within %0d cycles", cycles);
        end
    endtask

    task automatic runToRow(int target);
        int cycles;
        cycles = 0;
        while (mRow != target && cycles < 2000) begin
            stepCycle(1'b0, 1'b0, 1'b0, 1'b0);
            cycles++;
        end
        if (mRow != target) begin
            otherErrors++;
            $display("piece did not reach row %0d", target);
        end
    endtask

    ////////////////////
    // checks

    task automatic checkCube(logic actual, logic expected, int item);
        checks++;
        if (actual !== expected) begin
            cubeErrors++;
            $display("Mismatch at %0t: haveCube item %0d expected %b actual %b",
                $time, item, expected, actual);
        end
    endtask

    task automatic checkFlag(logic actual, logic expected);
        checks++;
        if (actual !== expected) begin
            flagErrors++;
            $display("Mismatch at %0t: flag expected %b actual %b", $time, expected, actual);
        end
    endtask

    task automatic checkFinish(logic actual, logic expected);
        checks++;
        if (actual !== expected) begin
            finishErrors++;
            $display("Mismatch at %0t: isFinish expected %b actual %b", $time, expected, actual);
        end
    endtask

    // center pixel of a board cell or a preview cell
    function automatic tetrisPkg::addrT itemAddr(int item);
        int line;
        int pixel;
        int half;
        half = tetrisPkg::cellPixels / 2;
        line = tetrisPkg::boardTop + (item / tetrisPkg::boardCols) * tetrisPkg::cellPixels;
        pixel = tetrisPkg::boardLeft + (item % tetrisPkg::boardCols) * tetrisPkg::cellPixels;
        if (item >= boardItems) begin
            line = tetrisPkg::previewTop + ((item - boardItems) / 4) * tetrisPkg::cellPixels;
            pixel = tetrisPkg::previewLeft + ((item - boardItems) % 4) * tetrisPkg::cellPixels;
        end
        return tetrisPkg::addrT'((line + half) * tetrisPkg::screenWidth + pixel + half);
    endfunction

    function automatic logic itemExpect(int item);
        int r;
        int c;
        if (item >= boardItems) begin
            return tetrisPkg::shapeTable[mNextIdx][item - boardItems];
        end
        r = item / tetrisPkg::boardCols;
        c = item % tetrisPkg::boardCols;
        return mBoard[r][c] | pieceAt(r, c);
    endfunction

    // haveCube at a negedge belongs to the address of the previous cycle
    task automatic scanScreen();
        repeat (3) stepCycle(1'b1, 1'b0, 1'b0, 1'b0);
        @(negedge clk);
        checkFlag(flag, expFlag);
        checkFinish(isFinish, expFinish);
        for (int i = 0; i <= scanItems; i++) begin
            stepCycle(1'b1, 1'b0, 1'b0, 1'b0);
            addr <= (i < scanItems) ? itemAddr(i) : '0;
            @(negedge clk);
            if (i > 0) begin
                checkCube(haveCube, itemExpect(i - 1), i - 1);
            end
        end
    endtask

    ////////////////////
    // directed tests

    task automatic resetTest();
        resetDut();
        stepCycle(1'b0, 1'b0, 1'b0, 1'b0);
        @(negedge clk);
        checkFlag(flag, expFlag);
        checkFinish(isFinish, expFinish);
        scanScreen();
    endtask

    task automatic gravityTest();
        int   target;
        int   spanLeft;
        logic fallNow;
        resetDut();
        target = 4 + randBits(4);
        spanLeft = 0;
        fallNow = 1'b0;
        while (mTicks < target) begin
            if (spanLeft == 0) begin
                spanLeft = 5 + randBits(5);
                fallNow = (randBits(1) == 1);
            end
            stepCycle(1'b0, fallNow, 1'b0, 1'b0);
            spanLeft--;
        end
        scanScreen();
        repeat (60) stepCycle(1'b1, 1'b1, 1'b0, 1'b0);
        scanScreen();
    endtask

    task automatic moveTest();
        resetDut();
        repeat (6) pressButton(randBits(1) == 1);
        repeat (8) pressButton(1'b1);
        scanScreen();
        repeat (8) pressButton(1'b0);
        scanScreen();
        // bar settles against the left wall and the T pushes into it
        repeat (8) pressButton(1'b1);
        dropPiece();
        pressButton(1'b0);
        runToRow(18);
        repeat (2) pressButton(1'b1);
        scanScreen();
    endtask

    task automatic landingTest();
        resetDut();
        repeat (3) begin
            dropPiece();
            scanScreen();
        end
    endtask

    task automatic gameOverTest();
        resetDut();
        repeat (25) begin
            if (!mOver) begin
                dropPiece();
            end
        end
        if (!mOver) begin
            otherErrors++;
            $display("game did not end after 25 pieces");
        end
        stepCycle(1'b0, 1'b0, 1'b0, 1'b0);
        @(negedge clk);
        checkFinish(isFinish, expFinish);
        checkFlag(flag, expFlag);
        scanScreen();
        repeat (3) pressButton(1'b1);
        repeat (3) pressButton(1'b0);
        repeat (80) stepCycle(1'b0, 1'b1, 1'b0, 1'b0);
        @(negedge clk);
        checkFinish(isFinish, expFinish);
        checkFlag(flag, expFlag);
        scanScreen();
    endtask

    initial begin
        #(watchLimitNs);
        $display("watchdog expired after %0d ns, the tests did not finish", watchLimitNs);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        int total;
        restart = 1'b0;
        left = 1'b0;
        right = 1'b0;
        fall = 1'b0;
        isPause = 1'b1;
        addr = '0;
        lfsr = 32'h558f_9dd5;
        checks = 0;
        cubeErrors = 0;
        flagErrors = 0;
        finishErrors = 0;
        otherErrors = 0;
        resetModel();
        resetTest();
        gravityTest();
        moveTest();
        landingTest();
        gameOverTest();
        total = cubeErrors + flagErrors + finishErrors + otherErrors;
        $display("checks %0d, haveCube errors %0d, flag errors %0d, isFinish errors %0d, other %0d",
            checks, cubeErrors, flagErrors, finishErrors, otherErrors);
        if (total == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* tb.f */
source/tetrisPkg.sv
source/buttonSync.sv
source/gravityTimer.sv
source/collisionCheck.sv
source/pieceController.sv
source/pixelLookup.sv
source/tetrisTop.sv
sim/tbClock.sv
sim/tetrisTb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tetrisTb -f tb.f -o simTetris

./obj_dir/simTetris | tee sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation passed"
